/* rtl/pio_isa_pkg.sv */
package pio_isa_pkg;

  localparam int INSTR_W  = 16;
  localparam int OPC_W    = 3;
  localparam int OPC_LSB  = 13;
  localparam int SEL_W    = 3;
  localparam int SEL_LSB  = 5;  // JMP condition or IN/OUT/SET target
  localparam int PULL_BIT = 7;  // PUSH_PULL direction select
  localparam int BITCNT_W = 5;  // Bit count or jump target

  typedef enum logic [OPC_W-1:0] {
    OP_JMP       = 3'd0,
    OP_IN        = 3'd2,
    OP_OUT       = 3'd3,
    OP_PUSH_PULL = 3'd4,
    OP_SET       = 3'd7
  } pio_opcode_e;

  typedef enum logic [SEL_W-1:0] {
    JMP_ALWAYS = 3'd0,
    JMP_X_ZERO = 3'd1,
    JMP_X_DEC  = 3'd2,  // Taken while X nonzero, X decrements anyway
    JMP_PIN    = 3'd6
  } pio_jmp_cond_e;

  typedef enum logic [SEL_W-1:0] {
    SD_PINS    = 3'd0,
    SD_X       = 3'd1,
    SD_NULL    = 3'd3,
    SD_PINDIRS = 3'd4
  } pio_src_dst_e;

endpackage

/* rtl/pio_cfg_pkg.sv */
package pio_cfg_pkg;

  localparam int NUM_SM     = 2;
  localparam int SM_W       = $clog2(NUM_SM);
  localparam int MEM_DEPTH  = 32;
  localparam int ADDR_W     = 5;
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
  localparam int DATA_W     = 32;
  localparam int DIV_W      = 24;
  localparam int CNT_W      = 3;  // Pin group size, 0 to 7 pins
  localparam int PIN_W      = 5;  // Pin number
  localparam int ACT_W      = 4;

  // Pin group layout of the PINS action word
  localparam int SET_CNT_LSB  = 0;
  localparam int SET_BASE_LSB = 3;
  localparam int OUT_CNT_LSB  = 8;
  localparam int OUT_BASE_LSB = 11;
  localparam int IN_BASE_LSB  = 19;

  typedef enum logic [ACT_W-1:0] {
    ACT_NOP     = 4'd0,
    ACT_INSTR   = 4'd1,
    ACT_WRAP    = 4'd2,
    ACT_PULL_RX = 4'd3,
    ACT_PUSH_TX = 4'd4,
    ACT_PINS    = 4'd5,
    ACT_ENABLE  = 4'd6,
    ACT_DIV     = 4'd7,
    ACT_IMM     = 4'd9,
    ACT_JMP_PIN = 4'd10
  } pio_action_e;

endpackage

/* rtl/pio_if.sv */
`timescale 1ns/1ns

interface pio_mcfg_if
  import pio_isa_pkg::*, pio_cfg_pkg::*;
();

  logic               en;
  logic [DIV_W-1:0]   div;
  logic [ADDR_W-1:0]  pstart;
  logic [ADDR_W-1:0]  pend;
  logic               imm_valid;    // One cycle pulse
  logic [INSTR_W-1:0] imm_instr;
  logic [PIN_W-1:0]   in_base;
  logic [PIN_W-1:0]   out_base;
  logic [CNT_W-1:0]   out_count;
  logic [PIN_W-1:0]   set_base;
  logic [CNT_W-1:0]   set_count;
  logic [PIN_W-1:0]   jmp_pin;

  modport ctrl (output en, div, pstart, pend, imm_valid, imm_instr,
                in_base, out_base, out_count, set_base, set_count, jmp_pin);
  modport fetch (input en, div, pstart, pend, imm_valid, imm_instr);
  modport exec (input in_base, out_base, out_count, set_base, set_count, jmp_pin);

endinterface

interface pio_issue_if
  import pio_isa_pkg::*, pio_cfg_pkg::*;
();

  logic               valid;
  logic [INSTR_W-1:0] instr;
  logic [ADDR_W-1:0]  pc;           // Address fetch reads after this issue
  logic               stall;
  logic               jump;
  logic [ADDR_W-1:0]  jump_target;

  modport fetch (output valid, instr, pc, input stall, jump, jump_target);
  modport exec (input valid, instr, pc, output stall, jump, jump_target);

endinterface

/* rtl/pio_fifo.sv */
`timescale 1ns/1ns

module pio_fifo
  import pio_cfg_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              push,
  input  logic              pull,
  input  logic [DATA_W-1:0] din,
  output logic [DATA_W-1:0] dout,
  output logic              full,
  output logic              empty
);

  logic [DATA_W-1:0]  mem [FIFO_DEPTH];
  logic [FIFO_AW:0]   wr_ptr;
  logic [FIFO_AW:0]   rd_ptr;

  // Extra pointer bit tells full from empty
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                 (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
  assign dout  = mem[rd_ptr[FIFO_AW-1:0]];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push && !full) wr_ptr <= wr_ptr + 1'b1;
      if (pull && !empty) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push && !full) mem[wr_ptr[FIFO_AW-1:0]] <= din;
  end

endmodule

/* rtl/pio_control.sv */
`timescale 1ns/1ns

module pio_control
  import pio_isa_pkg::*, pio_cfg_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  pio_action_e        action,
  input  logic [SM_W-1:0]    mindex,
  input  logic [ADDR_W-1:0]  index,
  input  logic [DATA_W-1:0]  din,
  pio_mcfg_if.ctrl           mcfg [NUM_SM],
  input  logic [ADDR_W-1:0]  rd_addr [NUM_SM],
  output logic [INSTR_W-1:0] rd_data [NUM_SM],
  output logic [NUM_SM-1:0]  tx_push,
  output logic [NUM_SM-1:0]  rx_pull
);

  logic [INSTR_W-1:0] mem [MEM_DEPTH];  // Shared program store

  logic [NUM_SM-1:0]  en_q;
  logic [NUM_SM-1:0]  imm_valid_q;
  logic [INSTR_W-1:0] imm_instr_q;
  logic [DIV_W-1:0]   div_q       [NUM_SM];
  logic [ADDR_W-1:0]  pstart_q    [NUM_SM];
  logic [ADDR_W-1:0]  pend_q      [NUM_SM];
  logic [PIN_W-1:0]   in_base_q   [NUM_SM];
  logic [PIN_W-1:0]   out_base_q  [NUM_SM];
  logic [CNT_W-1:0]   out_count_q [NUM_SM];
  logic [PIN_W-1:0]   set_base_q  [NUM_SM];
  logic [CNT_W-1:0]   set_count_q [NUM_SM];
  logic [PIN_W-1:0]   jmp_pin_q   [NUM_SM];

  always_ff @(posedge clk) begin
    if (action == ACT_INSTR) mem[index] <= din[INSTR_W-1:0];
    if (action == ACT_IMM) imm_instr_q <= din[INSTR_W-1:0];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      en_q        <= '0;
      imm_valid_q <= '0;
      for (int i = 0; i < NUM_SM; i++) begin
        div_q[i]       <= '0;
        pstart_q[i]    <= '0;
        pend_q[i]      <= '0;
        in_base_q[i]   <= '0;
        out_base_q[i]  <= '0;
        out_count_q[i] <= '0;
        set_base_q[i]  <= '0;
        set_count_q[i] <= '0;
        jmp_pin_q[i]   <= '0;
      end
    end else begin
      imm_valid_q <= '0;
      case (action)
        ACT_WRAP: begin
          pend_q[mindex]   <= index;
          pstart_q[mindex] <= din[ADDR_W-1:0];
        end
        ACT_PINS: begin                           // In count field is ignored
          set_count_q[mindex] <= din[SET_CNT_LSB +: CNT_W];
          set_base_q[mindex]  <= din[SET_BASE_LSB +: PIN_W];
          out_count_q[mindex] <= din[OUT_CNT_LSB +: CNT_W];
          out_base_q[mindex]  <= din[OUT_BASE_LSB +: PIN_W];
          in_base_q[mindex]   <= din[IN_BASE_LSB +: PIN_W];
        end
        ACT_ENABLE:  en_q <= din[NUM_SM-1:0];     // One bit per machine
        ACT_DIV:     div_q[mindex] <= din[DIV_W-1:0];
        ACT_IMM:     imm_valid_q[mindex] <= 1'b1;
        ACT_JMP_PIN: jmp_pin_q[mindex] <= din[PIN_W-1:0];
        default: ;
      endcase
    end
  end

  // FIFO strobes land in the FIFO on this edge, together with din
  always_comb begin
    tx_push = '0;
    rx_pull = '0;
    if (action == ACT_PUSH_TX) tx_push[mindex] = 1'b1;
    if (action == ACT_PULL_RX) rx_pull[mindex] = 1'b1;
  end

  for (genvar g = 0; g < NUM_SM; g++) begin : g_sm
    assign rd_data[g] = mem[rd_addr[g]];

    assign mcfg[g].en        = en_q[g];
    assign mcfg[g].div       = div_q[g];
    assign mcfg[g].pstart    = pstart_q[g];
    assign mcfg[g].pend      = pend_q[g];
    assign mcfg[g].imm_valid = imm_valid_q[g];
    assign mcfg[g].imm_instr = imm_instr_q;
    assign mcfg[g].in_base   = in_base_q[g];
    assign mcfg[g].out_base  = out_base_q[g];
    assign mcfg[g].out_count = out_count_q[g];
    assign mcfg[g].set_base  = set_base_q[g];
    assign mcfg[g].set_count = set_count_q[g];
    assign mcfg[g].jmp_pin   = jmp_pin_q[g];
  end

endmodule

/* rtl/pio_fetch.sv */
`timescale 1ns/1ns

module pio_fetch
  import pio_isa_pkg::*, pio_cfg_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  pio_mcfg_if.fetch          mcfg,
  pio_issue_if.fetch         issue,
  output logic [ADDR_W-1:0]  rd_addr,
  input  logic [INSTR_W-1:0] rd_data,
  output logic               tick
);

  logic [DIV_W-1:0]   div_cnt;
  logic [ADDR_W-1:0]  pc;
  logic [ADDR_W-1:0]  pc_nxt;
  logic               imm_pend;
  logic [INSTR_W-1:0] imm_q;
  logic               load;

  assign tick    = (div_cnt >= mcfg.div);  // Also safe when div shrinks
  assign rd_addr = pc;

  // A disabled machine drops a stalled issue so it cannot linger
  assign load = tick && !issue.jump && (!issue.stall || !mcfg.en);

  always_comb begin
    pc_nxt = pc;
    if (!mcfg.en) begin
      pc_nxt = mcfg.pstart;                  // Restart point on enable
    end else if (tick && issue.jump) begin
      pc_nxt = issue.jump_target;
    end else if (load && !imm_pend) begin
      pc_nxt = (pc == mcfg.pend) ? mcfg.pstart : pc + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= tick ? '0 : div_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= '0;
      imm_pend    <= 1'b0;
      issue.valid <= 1'b0;
    end else begin
      pc <= pc_nxt;
      if (tick && issue.jump) begin
        issue.valid <= 1'b0;                 // Bubble after a taken jump
      end else if (load) begin
        issue.valid <= mcfg.en || imm_pend;
        imm_pend    <= 1'b0;
      end
      if (mcfg.imm_valid) imm_pend <= 1'b1;  // Wait for the next tick
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      issue.instr <= imm_pend ? imm_q : rd_data;
      issue.pc    <= pc_nxt;
    end
    if (mcfg.imm_valid) imm_q <= mcfg.imm_instr;
  end

endmodule

/* rtl/pio_exec.sv */
`timescale 1ns/1ns

module pio_exec
  import pio_isa_pkg::*, pio_cfg_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              tick,
  pio_mcfg_if.exec          mcfg,
  pio_issue_if.exec         issue,
  input  logic [DATA_W-1:0] gpio_in,
  output logic [DATA_W-1:0] pins,
  output logic [DATA_W-1:0] pindirs,
  input  logic [DATA_W-1:0] tx_data,
  input  logic              tx_empty,
  output logic              tx_pull,
  output logic [DATA_W-1:0] rx_data,
  input  logic              rx_full,
  output logic              rx_push
);

  function automatic logic [DATA_W-1:0] rotl(input logic [DATA_W-1:0] v,
                                             input logic [PIN_W-1:0]  b);
    logic [2*DATA_W-1:0] w;
    w = {v, v} << b;
    return w[2*DATA_W-1:DATA_W];
  endfunction

  // Write cnt bits of val starting at base, wrapping past pin 31
  function automatic logic [DATA_W-1:0] pin_merge(input logic [DATA_W-1:0] old,
                                                  input logic [DATA_W-1:0] val,
                                                  input logic [PIN_W-1:0]  base,
                                                  input logic [CNT_W-1:0]  cnt);
    logic [DATA_W-1:0] mask;
    mask = rotl((DATA_W'(1) << cnt) - DATA_W'(1), base);
    return (old & ~mask) | (rotl(val, base) & mask);
  endfunction

  pio_opcode_e         opc;
  pio_jmp_cond_e       cond;
  pio_src_dst_e        sel;
  logic                pull_sel;
  logic [ADDR_W-1:0]   target;
  logic [BITCNT_W:0]   nbits;
  logic [DATA_W-1:0]   x;
  logic [DATA_W-1:0]   isr;
  logic [DATA_W-1:0]   osr;
  logic [DATA_W-1:0]   in_src;
  logic [DATA_W-1:0]   in_mask;
  logic [DATA_W-1:0]   out_val;
  logic [DATA_W-1:0]   set_val;
  logic                stall_c;
  logic                do_exec;
  logic                taken;

  assign opc      = pio_opcode_e'(issue.instr[OPC_LSB +: OPC_W]);
  assign cond     = pio_jmp_cond_e'(issue.instr[SEL_LSB +: SEL_W]);
  assign sel      = pio_src_dst_e'(issue.instr[SEL_LSB +: SEL_W]);
  assign pull_sel = issue.instr[PULL_BIT];
  assign target   = issue.instr[ADDR_W-1:0];
  assign nbits    = (issue.instr[BITCNT_W-1:0] == '0) ? (BITCNT_W+1)'(DATA_W)
                                                       : {1'b0, issue.instr[BITCNT_W-1:0]};

  assign stall_c = issue.valid && (opc == OP_PUSH_PULL) && (pull_sel ? tx_empty : rx_full);
  assign do_exec = tick && issue.valid && !stall_c;

  // Rotate right by in_base so the base pin lands in bit 0
  assign in_src  = (sel == SD_PINS) ? rotl(gpio_in, -mcfg.in_base) :
                   (sel == SD_X)    ? x : '0;
  assign in_mask = (DATA_W'(1) << nbits) - DATA_W'(1);  // All ones for 32
  assign out_val = osr >> (DATA_W - nbits);             // Left shift, MSBs out first
  assign set_val = DATA_W'(issue.instr[BITCNT_W-1:0]);

  always_comb begin
    case (cond)
      JMP_ALWAYS: taken = 1'b1;
      JMP_X_ZERO: taken = (x == '0);
      JMP_X_DEC:  taken = (x != '0);
      JMP_PIN:    taken = gpio_in[mcfg.jmp_pin];
      default:    taken = 1'b0;
    endcase
  end

  assign issue.stall       = stall_c;
  // No redirect when fetch already holds the target
  assign issue.jump        = do_exec && (opc == OP_JMP) && taken && (target != issue.pc);
  assign issue.jump_target = target;

  assign tx_pull = do_exec && (opc == OP_PUSH_PULL) && pull_sel;
  assign rx_push = do_exec && (opc == OP_PUSH_PULL) && !pull_sel;
  assign rx_data = isr;

  always_ff @(posedge clk) begin
    if (reset) begin
      x       <= '0;
      isr     <= '0;
      osr     <= '0;
      pins    <= '0;
      pindirs <= '0;
    end else if (do_exec) begin
      case (opc)
        OP_JMP: begin
          if (cond == JMP_X_DEC) x <= x - 1'b1;
        end
        OP_IN: isr <= (isr << nbits) | (in_src & in_mask);
        OP_OUT: begin
          osr <= osr << nbits;
          case (sel)
            SD_PINS: pins <= pin_merge(pins, out_val, mcfg.out_base, mcfg.out_count);
            SD_X:    x <= out_val;
            default: ;                      // NULL discards
          endcase
        end
        OP_PUSH_PULL: begin
          if (pull_sel) osr <= tx_data;
          else isr <= '0;                   // ISR empties on push
        end
        OP_SET: begin
          case (sel)
            SD_PINS:    pins <= pin_merge(pins, set_val, mcfg.set_base, mcfg.set_count);
            SD_PINDIRS: pindirs <= pin_merge(pindirs, set_val, mcfg.set_base, mcfg.set_count);
            SD_X:       x <= set_val;
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

/* rtl/pio.sv */
`timescale 1ns/1ns

module pio
  import pio_isa_pkg::*, pio_cfg_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic [SM_W-1:0]   mindex,
  input  logic [DATA_W-1:0] din,
  input  logic [ADDR_W-1:0] index,
  input  logic [ACT_W-1:0]  action,
  output logic [DATA_W-1:0] dout,
  input  logic [DATA_W-1:0] gpio_in,
  output logic [DATA_W-1:0] gpio_out,
  output logic [DATA_W-1:0] gpio_dir,
  output logic [NUM_SM-1:0] rx_empty,
  output logic [NUM_SM-1:0] tx_full
);

  pio_mcfg_if mcfg [NUM_SM] ();

  logic [ADDR_W-1:0]  rd_addr [NUM_SM];
  logic [INSTR_W-1:0] rd_data [NUM_SM];
  logic [NUM_SM-1:0]  tx_push;
  logic [NUM_SM-1:0]  tx_pull;
  logic [NUM_SM-1:0]  tx_empty;
  logic [NUM_SM-1:0]  rx_push;
  logic [NUM_SM-1:0]  rx_pull;
  logic [NUM_SM-1:0]  rx_full;
  logic [DATA_W-1:0]  tx_data [NUM_SM];
  logic [DATA_W-1:0]  rx_din  [NUM_SM];
  logic [DATA_W-1:0]  rx_dout [NUM_SM];
  logic [DATA_W-1:0]  pins    [NUM_SM];
  logic [DATA_W-1:0]  dirs    [NUM_SM];

  pio_control u_control (
    .clk     (clk),
    .reset   (reset),
    .action  (pio_action_e'(action)),
    .mindex  (mindex),
    .index   (index),
    .din     (din),
    .mcfg    (mcfg),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .tx_push (tx_push),
    .rx_pull (rx_pull)
  );

  for (genvar g = 0; g < NUM_SM; g++) begin : g_sm
    pio_issue_if issue ();
    logic        tick;

    pio_fetch u_fetch (
      .clk     (clk),
      .reset   (reset),
      .mcfg    (mcfg[g]),
      .issue   (issue),
      .rd_addr (rd_addr[g]),
      .rd_data (rd_data[g]),
      .tick    (tick)
    );

    pio_exec u_exec (
      .clk      (clk),
      .reset    (reset),
      .tick     (tick),
      .mcfg     (mcfg[g]),
      .issue    (issue),
      .gpio_in  (gpio_in),
      .pins     (pins[g]),
      .pindirs  (dirs[g]),
      .tx_data  (tx_data[g]),
      .tx_empty (tx_empty[g]),
      .tx_pull  (tx_pull[g]),
      .rx_data  (rx_din[g]),
      .rx_full  (rx_full[g]),
      .rx_push  (rx_push[g])
    );

    pio_fifo u_tx (                         // Host to machine
      .clk   (clk),
      .reset (reset),
      .push  (tx_push[g]),
      .pull  (tx_pull[g]),
      .din   (din),
      .dout  (tx_data[g]),
      .full  (tx_full[g]),
      .empty (tx_empty[g])
    );

    pio_fifo u_rx (                         // Machine to host
      .clk   (clk),
      .reset (reset),
      .push  (rx_push[g]),
      .pull  (rx_pull[g]),
      .din   (rx_din[g]),
      .dout  (rx_dout[g]),
      .full  (rx_full[g]),
      .empty (rx_empty[g])
    );
  end

  always_comb begin
    gpio_out = '0;
    gpio_dir = '0;
    for (int i = 0; i < NUM_SM; i++) begin
      gpio_out |= pins[i];
      gpio_dir |= dirs[i];
    end
  end

  assign dout = rx_dout[mindex];

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

/* dv/pio_tb.sv */
`timescale 1ns/1ns

module pio_tb
  import pio_isa_pkg::*, pio_cfg_pkg::*;
();

  localparam int NUM_TESTS = 8;
  localparam int LIMIT     = 200;  // Cycles per wait

  typedef struct packed {
    logic              both;       // Machines 0 and 1 together
    logic [SM_W-1:0]   sm;
    logic [7:0][15:0]  prog;
    logic [3:0]        plen;
    logic [4:0]        pend;
    logic [7:0]        div;
    logic [4:0]        in_base;
    logic [4:0]        out_base;
    logic [2:0]        out_cnt;
    logic [4:0]        set_base;
    logic [2:0]        set_cnt;
    logic [4:0]        jmp_pin;
    logic [31:0]       gpio;
    logic [3:0]        n_tx;       // Per machine
    logic [7:0][31:0]  tx;
    logic [3:0]        n_rx;
    logic [7:0][31:0]  rx;
    logic              chk_pins;
    logic [31:0]       exp_out;
    logic [31:0]       exp_dir;
    logic              imm;        // Immediate on the higher machine
    logic [15:0]       imm_instr;
  } test_t;

  logic              clk;
  logic              reset;
  logic [SM_W-1:0]   mindex;
  logic [DATA_W-1:0] din;
  logic [ADDR_W-1:0] index;
  logic [ACT_W-1:0]  action;
  logic [DATA_W-1:0] dout;
  logic [DATA_W-1:0] gpio_in;
  logic [DATA_W-1:0] gpio_out;
  logic [DATA_W-1:0] gpio_dir;
  logic [NUM_SM-1:0] rx_empty;
  logic [NUM_SM-1:0] tx_full;

  logic [31:0] lfsr;
  test_t       tests [NUM_TESTS];
  string       names [NUM_TESTS];
  int          errors;
  int          passed;
  int          failed;

  tb_clock u_clock (.clk(clk), .reset(reset));

  pio UUT (
    .clk      (clk),
    .reset    (reset),
    .mindex   (mindex),
    .din      (din),
    .index    (index),
    .action   (action),
    .dout     (dout),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_dir (gpio_dir),
    .rx_empty (rx_empty),
    .tx_full  (tx_full)
  );

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // Taps 32 22 2 1
      w = {w[30:0], lfsr[0]};
    end
    return w;
  endfunction

  function automatic logic [15:0] enc(input logic [2:0] opc, input logic [2:0] sel,
                                      input logic [4:0] bits);
    return {opc, 5'b0, sel, bits};  // Delay field unused
  endfunction

  function automatic logic [31:0] pins_word(input logic [4:0] in_base,
                                            input logic [4:0] out_base,
                                            input logic [2:0] out_cnt,
                                            input logic [4:0] set_base,
                                            input logic [2:0] set_cnt);
    logic [31:0] w;
    w = '0;
    w[SET_CNT_LSB +: CNT_W]  = set_cnt;
    w[SET_BASE_LSB +: PIN_W] = set_base;
    w[OUT_CNT_LSB +: CNT_W]  = out_cnt;
    w[OUT_BASE_LSB +: PIN_W] = out_base;
    w[IN_BASE_LSB +: PIN_W]  = in_base;
    return w;
  endfunction

  // Expected pin state, cnt bits from base upward, wrapping past 31
  function automatic logic [31:0] pin_model(input logic [31:0] old, input logic [31:0] val,
                                            input int base, input int cnt);
    logic [31:0] r;
    r = old;
    for (int i = 0; i < cnt; i++) r[(base + i) % 32] = val[i];
    return r;
  endfunction

  function automatic test_t echo_test(input int sm, input int div, input int n,
                                      input logic both);
    test_t t;
    t = '0;
    t.both    = both;
    t.sm      = SM_W'(sm);
    t.prog[0] = enc(OP_PUSH_PULL, 3'b100, 5'd0);
    t.prog[1] = enc(OP_OUT, SD_X, 5'd0);
    t.prog[2] = enc(OP_IN, SD_X, 5'd0);
    t.prog[3] = enc(OP_PUSH_PULL, 3'b000, 5'd0);
    t.plen    = 4;
    t.pend    = 3;
    t.div     = 8'(div);
    t.n_tx    = 4'(n);
    t.n_rx    = 4'(n);
    for (int i = 0; i < (both ? 2 * n : n); i++) begin
      t.tx[i] = rand_word();
      t.rx[i] = t.tx[i];  // Echo returns each word
    end
    return t;
  endfunction

  task automatic build_table();
    test_t       t;
    logic [31:0] p0;
    logic [31:0] d0;
    tests[0] = echo_test(0, 0, 4, 1'b0);
    names[0] = "echo div 0";
    tests[1] = echo_test(1, 3, 4, 1'b0);
    names[1] = "echo div 3";
    tests[2] = echo_test(0, 0, 8, 1'b0);
    names[2] = "echo with stalls";

    t = '0;
    t.prog[0] = enc(OP_SET, SD_X, 5'd3);
    t.prog[1] = enc(OP_IN, SD_X, 5'd8);
    t.prog[2] = enc(OP_PUSH_PULL, 3'b000, 5'd0);
    t.prog[3] = enc(OP_JMP, JMP_X_DEC, 5'd1);
    t.prog[4] = enc(OP_PUSH_PULL, 3'b100, 5'd0);  // Blocks with nothing sent
    t.plen    = 5;
    t.pend    = 4;
    t.div     = 1;
    t.n_rx    = 4;
    for (int i = 0; i < 4; i++) t.rx[i] = 32'(3 - i);
    tests[3] = t;
    names[3] = "counted loop";

    t = '0;
    t.prog[0]  = enc(OP_SET, SD_PINDIRS, 5'h1f);
    t.prog[1]  = enc(OP_SET, SD_PINS, 5'h1b);
    t.prog[2]  = enc(OP_PUSH_PULL, 3'b100, 5'd0);
    t.prog[3]  = enc(OP_OUT, SD_PINS, 5'd6);       // Two bits more than out_cnt
    t.prog[4]  = enc(OP_PUSH_PULL, 3'b000, 5'd0);  // Marker word, ISR empty
    t.prog[5]  = enc(OP_PUSH_PULL, 3'b100, 5'd0);
    t.plen     = 6;
    t.pend     = 5;
    t.out_base = 29;
    t.out_cnt  = 4;
    t.set_base = 30;
    t.set_cnt  = 4;
    t.n_tx     = 1;
    t.tx[0]    = rand_word();
    t.n_rx     = 1;
    d0 = pin_model('0, 32'h1f, 30, 4);
    p0 = pin_model(pin_model('0, 32'h1b, 30, 4), t.tx[0] >> 26, 29, 4);
    t.chk_pins = 1'b1;
    t.exp_out  = p0;
    t.exp_dir  = d0;
    tests[4] = t;
    names[4] = "pin outputs";

    for (int k = 0; k < 2; k++) begin
      t = '0;
      t.sm      = 1;
      t.prog[0] = enc(OP_IN, SD_PINS, 5'd5);
      t.prog[1] = enc(OP_PUSH_PULL, 3'b000, 5'd0);
      t.prog[2] = enc(OP_SET, SD_X, 5'd7);
      t.prog[3] = enc(OP_JMP, JMP_PIN, 5'd5);
      t.prog[4] = enc(OP_SET, SD_X, 5'd9);        // Only when pin is low
      t.prog[5] = enc(OP_IN, SD_X, 5'd5);
      t.prog[6] = enc(OP_PUSH_PULL, 3'b000, 5'd0);
      t.prog[7] = enc(OP_PUSH_PULL, 3'b100, 5'd0);
      t.plen    = 8;
      t.pend    = 7;
      t.in_base = 9;
      t.jmp_pin = 5'(k);                           // Bit 0 high, bit 1 low
      t.gpio    = 32'h5a3c_96e1;
      t.n_rx    = 2;
      t.rx[0]   = (t.gpio >> 9) & 32'h1f;
      t.rx[1]   = t.gpio[t.jmp_pin] ? 32'd7 : 32'd9;
      tests[5 + k] = t;
    end
    names[5] = "pin in, jump taken";
    names[6] = "pin in, no jump";

    t = echo_test(0, 0, 4, 1'b1);
    t.set_base  = 10;
    t.set_cnt   = 4;
    t.imm       = 1'b1;
    t.imm_instr = enc(OP_SET, SD_PINS, 5'h1b);
    t.chk_pins  = 1'b1;
    t.exp_out   = p0 | pin_model('0, 32'h1b, 10, 4);
    t.exp_dir   = d0;
    tests[7] = t;
    names[7] = "two machines, immediate";
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic host(input logic [ACT_W-1:0] act, input int m, input int idx,
                      input logic [DATA_W-1:0] d);
    action = act;
    mindex = SM_W'(m);
    index  = ADDR_W'(idx);
    din    = d;
    step();
    action = ACT_NOP;
  endtask

  task automatic wait_space(input int m, output bit ok);
    int n;
    n = 0;
    while (tx_full[m] && n < LIMIT) begin
      step();
      n++;
    end
    ok = !tx_full[m];
    if (!ok) begin
      $display("Timeout: transmit FIFO of machine %0d never drained", m);
      errors++;
    end
  endtask

  task automatic wait_rx(input int m, output bit ok);
    int n;
    n = 0;
    mindex = SM_W'(m);
    step();                                // Let dout follow mindex
    while (rx_empty[m] && n < LIMIT) begin
      step();
      n++;
    end
    ok = !rx_empty[m];
    if (!ok) begin
      $display("Timeout: machine %0d never produced output", m);
      errors++;
    end
  endtask

  task automatic tally(input string name, input int base_err);
    if (errors == base_err) begin
      passed++;
      $display("%s: ok", name);
    end else begin
      failed++;
      $display("%s: %0d errors", name, errors - base_err);
    end
  endtask

  task automatic run_test(input test_t t, input string name);
    int          lo;
    int          hi;
    int          n;
    int          base_err;
    bit          ok;
    logic [31:0] got;
    base_err = errors;
    lo = t.both ? 0 : int'(t.sm);
    hi = t.both ? 1 : int'(t.sm);
    ok = 1'b1;
    gpio_in = t.gpio;
    for (int a = 0; a < t.plen; a++) host(ACT_INSTR, 0, a, 32'(t.prog[a]));
    for (int m = lo; m <= hi; m++) begin
      host(ACT_WRAP, m, t.pend, 32'd0);
      host(ACT_DIV, m, 0, 32'(t.div));
      host(ACT_PINS, m, 0, pins_word(t.in_base, t.out_base, t.out_cnt, t.set_base, t.set_cnt));
      host(ACT_JMP_PIN, m, 0, 32'(t.jmp_pin));
    end
    host(ACT_ENABLE, 0, 0, t.both ? 32'd3 : 32'd1 << t.sm);
    for (int m = lo; m <= hi; m++) begin
      for (int i = 0; i < t.n_tx && ok; i++) begin
        wait_space(m, ok);
        if (ok) host(ACT_PUSH_TX, m, 0, t.tx[(m - lo) * t.n_tx + i]);
      end
    end
    for (int m = lo; m <= hi; m++) begin
      for (int i = 0; i < t.n_rx && ok; i++) begin
        n = (m - lo) * t.n_rx + i;
        wait_rx(m, ok);
        if (ok) begin
          got = dout;
          assert (got == t.rx[n]) else begin
            $display("[FAIL] %0t %s: machine %0d word %0d expected %h got %h",
                     $time, name, m, i, t.rx[n], got);
            errors++;
          end
          host(ACT_PULL_RX, m, 0, 32'd0);
        end
      end
    end
    repeat (20) step();                    // Machines should be idle now
    assert (&rx_empty) else begin
      $display("[FAIL] %0t %s: extra receive words, rx_empty %b", $time, name, rx_empty);
      errors++;
    end
    host(ACT_ENABLE, 0, 0, 32'd0);
    if (t.imm) begin
      host(ACT_IMM, hi, 0, 32'(t.imm_instr));
      n = 0;
      while (gpio_out != t.exp_out && n < LIMIT) begin
        step();
        n++;
      end
    end
    if (t.chk_pins) begin
      assert (gpio_out == t.exp_out) else begin
        $display("[FAIL] %0t %s: gpio_out expected %h got %h", $time, name, t.exp_out, gpio_out);
        errors++;
      end
      assert (gpio_dir == t.exp_dir) else begin
        $display("[FAIL] %0t %s: gpio_dir expected %h got %h", $time, name, t.exp_dir, gpio_dir);
        errors++;
      end
    end
    tally(name, base_err);
  endtask

  initial begin
    int n;
    lfsr    = 32'd88;
    errors  = 0;
    passed  = 0;
    failed  = 0;
    action  = ACT_NOP;
    mindex  = '0;
    index   = '0;
    din     = '0;
    gpio_in = '0;
    build_table();
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (reset && n < 20);
    if (reset) begin
      $display("Timeout: reset was never released");
      errors++;
    end
    step();
    assert (gpio_out == '0 && gpio_dir == '0 && &rx_empty && tx_full == '0) else begin
      $display("[FAIL] %0t reset: gpio_out %h gpio_dir %h rx_empty %b tx_full %b",
               $time, gpio_out, gpio_dir, rx_empty, tx_full);
      errors++;
    end
    tally("reset state", 0);
    for (int k = 0; k < NUM_TESTS; k++) run_test(tests[k], names[k]);
    $display("%0d tests: %0d passed, %0d failed, %0d errors",
             passed + failed, passed, failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* src.f */
rtl/pio_isa_pkg.sv
rtl/pio_cfg_pkg.sv
rtl/pio_if.sv
rtl/pio_fifo.sv
rtl/pio_control.sv
rtl/pio_fetch.sv
rtl/pio_exec.sv
rtl/pio.sv
dv/tb_clock.sv
dv/pio_tb.sv

/* Bender.yml */
package:
  name: pio

sources:
  - rtl/pio_isa_pkg.sv
  - rtl/pio_cfg_pkg.sv
  - rtl/pio_if.sv
  - rtl/pio_fifo.sv
  - rtl/pio_control.sv
  - rtl/pio_fetch.sv
  - rtl/pio_exec.sv
  - rtl/pio.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/pio_tb.sv
